// ==== rtl/noc_io_link_pkg.sv ====
// noc io link constants
// link flit format, token credit depth and serial tag frame layout

package noc_io_link_pkg;

  ////////////////////////////////////////
  // link channel

  // flit width on the link and at the core side
  localparam int LINK_DATA_W = 16;

  // remote rx buffer depth, also the credit count after enable
  localparam int LINK_CREDITS = 4;

  // holds 0 through LINK_CREDITS
  localparam int CREDIT_W = 3;

  // local tx buffer depth, power of two
  localparam int TX_FIFO_DEPTH = 4;

  ////////////////////////////////////////
  // serial tag

  // node id width inside a frame
  localparam int TAG_ID_W = 4;

  // id this endpoint answers to
  localparam logic [TAG_ID_W-1:0] TAG_NODE_ID = 4'd5;

  // start bit, id bits msb first, enable bit
  localparam int TAG_FRAME_LEN = 6;

  // frame bit index counter
  localparam int TAG_CNT_W = $clog2(TAG_FRAME_LEN);

  ////////////////////////////////////////
  // payload

  // one flit as it travels over the link
  typedef logic [LINK_DATA_W-1:0] flit_t;

endpackage

// ==== rtl/tag_client_fsm.sv ====
// serial tag client
// collects tag frames bit by bit and holds the link enable for this node

`timescale 1ns/1ps

module tag_client_fsm
  (
    input  logic io_clk_i,
    input  logic rst_n_i,
    input  logic tag_en_i,
    input  logic tag_data_i,
    output logic link_en_o
  );

  typedef enum logic [1:0]
  {
    ST_IDLE   = 2'd0,
    ST_ID     = 2'd1,
    ST_ENABLE = 2'd2,
    ST_APPLY  = 2'd3
  } state_t;

  state_t state_q;
  state_t state_d;

  // index of the next frame bit
  logic [noc_io_link_pkg::TAG_CNT_W-1:0] bit_cnt_q;
  logic [noc_io_link_pkg::TAG_ID_W-1:0]  id_q;
  logic                                  en_bit_q;
  logic                                  link_en_q;

  // data gated with the enable, as on the chip pins
  logic tag_bit;
  assign tag_bit = tag_en_i & tag_data_i;

  ////////////////////////////////////////
  // next state

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
        if (tag_en_i && tag_bit)
          state_d = ST_ID;
      // last id bit moves on to the enable bit
      ST_ID:
        if (tag_en_i && (bit_cnt_q == noc_io_link_pkg::TAG_CNT_W'(
                           noc_io_link_pkg::TAG_FRAME_LEN - 2)))
          state_d = ST_ENABLE;
      ST_ENABLE:
        if (tag_en_i)
          state_d = ST_APPLY;
      // a start bit right behind the frame is not lost
      ST_APPLY:
        state_d = (tag_en_i && tag_bit) ? ST_ID : ST_IDLE;
      default:
        state_d = ST_IDLE;
    endcase
  end

  ////////////////////////////////////////
  // frame registers

  always_ff @(posedge io_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q   <= ST_IDLE;
      bit_cnt_q <= '0;
      id_q      <= '0;
      en_bit_q  <= 1'b0;
      link_en_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // start bit seen, id bits follow
      if (state_d == ST_ID && state_q != ST_ID)
        bit_cnt_q <= noc_io_link_pkg::TAG_CNT_W'(1);
      else if (tag_en_i && (state_q == ST_ID || state_q == ST_ENABLE))
        bit_cnt_q <= bit_cnt_q + 1'b1;
      // id shifts in msb first
      if (state_q == ST_ID && tag_en_i)
        id_q <= {id_q[noc_io_link_pkg::TAG_ID_W-2:0], tag_bit};
      if (state_q == ST_ENABLE && tag_en_i)
        en_bit_q <= tag_bit;
      // only frames addressed to this node touch the enable
      if (state_q == ST_APPLY && id_q == noc_io_link_pkg::TAG_NODE_ID)
        link_en_q <= en_bit_q;
    end
  end

  assign link_en_o = link_en_q;

  // bit counter stays in step with the frame state
  a_no_restart_mid_id: assert property (
    @(posedge io_clk_i) disable iff (!rst_n_i)
    (state_q inside {ST_ID, ST_ENABLE}) |->
      (bit_cnt_q != '0) &&
      ((state_q == ST_ENABLE) ==
       (bit_cnt_q == noc_io_link_pkg::TAG_CNT_W'(noc_io_link_pkg::TAG_FRAME_LEN - 1)))
  );

endmodule

// ==== rtl/credit_counter.sv ====
// token credit counter
// one credit per free slot in the remote rx buffer, sending spends one

`timescale 1ns/1ps

module credit_counter
  (
    input  logic io_clk_i,
    input  logic rst_n_i,
    input  logic link_en_i,
    input  logic send_i,
    input  logic token_i,
    output logic credit_avail_o
  );

  logic [noc_io_link_pkg::CREDIT_W-1:0] credit_q;

  ////////////////////////////////////////
  // credit count

  always_ff @(posedge io_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      credit_q <= noc_io_link_pkg::CREDIT_W'(noc_io_link_pkg::LINK_CREDITS);
    // disabled link starts over with a full remote buffer
    else if (!link_en_i)
      credit_q <= noc_io_link_pkg::CREDIT_W'(noc_io_link_pkg::LINK_CREDITS);
    else if (send_i && !token_i)
      credit_q <= credit_q - 1'b1;
    else if (token_i && !send_i)
      credit_q <= credit_q + 1'b1;
    // send and token together cancel out
  end

  assign credit_avail_o = (credit_q != '0);

  // tx side only sends with a credit in hand
  a_no_underflow: assert property (
    @(posedge io_clk_i) disable iff (!rst_n_i)
    (link_en_i && send_i) |-> (credit_q != '0)
  );

  // remote never returns more tokens than flits it got
  a_no_overflow: assert property (
    @(posedge io_clk_i) disable iff (!rst_n_i)
    (link_en_i && token_i && !send_i) |->
      (credit_q < noc_io_link_pkg::CREDIT_W'(noc_io_link_pkg::LINK_CREDITS))
  );

endmodule

// ==== rtl/flit_fifo.sv ====
// flit buffer
// circular buffer of flits, head shown on data_o while v_o is high

`timescale 1ns/1ps

module flit_fifo
  #(
    // power of two so the pointers wrap on their own
    parameter int DEPTH = 4
  )
  (
    input  logic                    io_clk_i,
    input  logic                    rst_n_i,
    input  logic                    v_i,
    input  noc_io_link_pkg::flit_t  data_i,
    input  logic                    yumi_i,
    output logic                    full_o,
    output logic                    v_o,
    output noc_io_link_pkg::flit_t  data_o
  );

  noc_io_link_pkg::flit_t mem_q [DEPTH];

  logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;

  ////////////////////////////////////////
  // storage

  always_ff @(posedge io_clk_i)
  begin
    if (v_i)
      mem_q[wr_ptr_q] <= data_i;
  end

  ////////////////////////////////////////
  // pointers and occupancy

  always_ff @(posedge io_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (v_i)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (yumi_i)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      // write and dequeue in one cycle leave the count alone
      case ({v_i, yumi_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign full_o = (int'(count_q) == DEPTH);
  assign v_o    = (count_q != '0);
  assign data_o = mem_q[rd_ptr_q];

  // writer must respect full, credits keep the rx side honest
  a_no_write_full: assert property (
    @(posedge io_clk_i) disable iff (!rst_n_i)
    v_i |-> !full_o
  );

  a_no_yumi_empty: assert property (
    @(posedge io_clk_i) disable iff (!rst_n_i)
    yumi_i |-> v_o
  );

endmodule

// ==== rtl/link_tx.sv ====
// link transmit channel
// buffers core flits, sends one per cycle while a token credit is held

`timescale 1ns/1ps

module link_tx
  (
    input  logic                   io_clk_i,
    input  logic                   rst_n_i,
    input  logic                   link_en_i,
    input  logic                   core_v_i,
    input  noc_io_link_pkg::flit_t core_data_i,
    input  logic                   link_token_i,
    output logic                   core_ready_o,
    output logic                   link_v_o,
    output noc_io_link_pkg::flit_t link_data_o
  );

  logic                   fifo_full;
  logic                   fifo_v;
  noc_io_link_pkg::flit_t fifo_data;
  logic                   credit_avail;
  logic                   send;
  logic                   link_v_q;
  noc_io_link_pkg::flit_t link_data_q;

  // no flits taken from the core while disabled
  assign core_ready_o = link_en_i & ~fifo_full;

  // head leaves when enabled and the remote has room
  assign send = fifo_v & link_en_i & credit_avail;

  flit_fifo #(.DEPTH(noc_io_link_pkg::TX_FIFO_DEPTH)) tx_fifo
  (
    .io_clk_i (io_clk_i),
    .rst_n_i  (rst_n_i),
    .v_i      (core_v_i & core_ready_o),
    .data_i   (core_data_i),
    .yumi_i   (send),
    .full_o   (fifo_full),
    .v_o      (fifo_v),
    .data_o   (fifo_data)
  );

  credit_counter credits
  (
    .io_clk_i       (io_clk_i),
    .rst_n_i        (rst_n_i),
    .link_en_i      (link_en_i),
    .send_i         (send),
    .token_i        (link_token_i),
    .credit_avail_o (credit_avail)
  );

  ////////////////////////////////////////
  // registered link output

  always_ff @(posedge io_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      link_v_q <= 1'b0;
    else
      link_v_q <= send;
  end

  always_ff @(posedge io_clk_i)
  begin
    if (send)
      link_data_q <= fifo_data;
  end

  assign link_v_o    = link_v_q;
  assign link_data_o = link_data_q;

endmodule

// ==== rtl/link_rx.sv ====
// link receive channel
// buffers link flits for the core, one token back per dequeue

`timescale 1ns/1ps

module link_rx
  (
    input  logic                   io_clk_i,
    input  logic                   rst_n_i,
    input  logic                   link_v_i,
    input  noc_io_link_pkg::flit_t link_data_i,
    input  logic                   out_yumi_i,
    output logic                   link_token_o,
    output logic                   out_v_o,
    output noc_io_link_pkg::flit_t out_data_o
  );

  logic token_q;

  // sized to the credits the remote starts with, so it never overflows
  flit_fifo #(.DEPTH(noc_io_link_pkg::LINK_CREDITS)) rx_fifo
  (
    .io_clk_i (io_clk_i),
    .rst_n_i  (rst_n_i),
    .v_i      (link_v_i),
    .data_i   (link_data_i),
    .yumi_i   (out_yumi_i),
    .full_o   (),
    .v_o      (out_v_o),
    .data_o   (out_data_o)
  );

  ////////////////////////////////////////
  // token return

  // freed slot goes back to the remote one cycle later
  always_ff @(posedge io_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      token_q <= 1'b0;
    else
      token_q <= out_yumi_i;
  end

  assign link_token_o = token_q;

endmodule

// ==== rtl/noc_io_link.sv ====
// noc io link endpoint
// tag client plus credit based tx and rx channels on one clock

`timescale 1ns/1ps

module noc_io_link
  (
    input  logic                   io_clk_i,
    input  logic                   rst_n_i,

    // serial tag
    input  logic                   tag_en_i,
    input  logic                   tag_data_i,

    // core to link
    input  logic                   core_v_i,
    input  noc_io_link_pkg::flit_t core_data_i,
    output logic                   core_ready_o,

    // link out
    output logic                   link_v_o,
    output noc_io_link_pkg::flit_t link_data_o,
    input  logic                   link_token_i,

    // link in
    input  logic                   link_v_i,
    input  noc_io_link_pkg::flit_t link_data_i,
    output logic                   link_token_o,

    // link to core
    output logic                   out_v_o,
    output noc_io_link_pkg::flit_t out_data_o,
    input  logic                   out_yumi_i
  );

  // enable from tag config, gates the tx side
  logic link_en;

  ////////////////////////////////////////
  // tag config

  tag_client_fsm tag_client
  (
    .io_clk_i   (io_clk_i),
    .rst_n_i    (rst_n_i),
    .tag_en_i   (tag_en_i),
    .tag_data_i (tag_data_i),
    .link_en_o  (link_en)
  );

  ////////////////////////////////////////
  // channels

  link_tx tx
  (
    .io_clk_i     (io_clk_i),
    .rst_n_i      (rst_n_i),
    .link_en_i    (link_en),
    .core_v_i     (core_v_i),
    .core_data_i  (core_data_i),
    .link_token_i (link_token_i),
    .core_ready_o (core_ready_o),
    .link_v_o     (link_v_o),
    .link_data_o  (link_data_o)
  );

  link_rx rx
  (
    .io_clk_i     (io_clk_i),
    .rst_n_i      (rst_n_i),
    .link_v_i     (link_v_i),
    .link_data_i  (link_data_i),
    .out_yumi_i   (out_yumi_i),
    .link_token_o (link_token_o),
    .out_v_o      (out_v_o),
    .out_data_o   (out_data_o)
  );

endmodule

// ==== test/noc_io_link_tb.sv ====
// noc io link testbench
// remote link model, serial tag frames, flit order and token return checks

`timescale 1ns/1ps

module noc_io_link_tb;

  localparam int SEED           = 32'h1443;
  localparam int TIMEOUT_CYCLES = 200;
  localparam int RANDOM_FLITS   = 24;

  logic                   io_clk_i = 1'b0;
  logic                   rst_n_i;
  logic                   tag_en_i;
  logic                   tag_data_i;
  logic                   core_v_i;
  noc_io_link_pkg::flit_t core_data_i;
  logic                   core_ready_o;
  logic                   link_v_o;
  noc_io_link_pkg::flit_t link_data_o;
  logic                   link_token_i = 1'b0;
  logic                   link_v_i;
  noc_io_link_pkg::flit_t link_data_i;
  logic                   link_token_o;
  logic                   out_v_o;
  noc_io_link_pkg::flit_t out_data_o;
  logic                   out_yumi_i;

  // expected flits per direction, in acceptance order
  noc_io_link_pkg::flit_t tx_expect[$];
  noc_io_link_pkg::flit_t rx_expect[$];

  int   errors            = 0;
  int   test_errors_start = 0;
  int   tests_run         = 0;
  int   tests_failed      = 0;
  int   link_v_count      = 0;
  int   held_sends        = 0;
  int   rx_deqs           = 0;
  int   token_pulses      = 0;
  int   owed_tokens       = 0;
  int   token_gap         = 0;
  logic hold_tokens       = 1'b0;

  noc_io_link dut_i (.*);

  always #10 io_clk_i = ~io_clk_i;

  ////////////////////////////////////////
  // reference and helpers

  // sent from the top bit down
  function automatic logic [noc_io_link_pkg::TAG_FRAME_LEN-1:0] tag_frame_bits(
    input logic [noc_io_link_pkg::TAG_ID_W-1:0] id,
    input logic                                 en
  );
    return {1'b1, id, en};
  endfunction

  task automatic check_level(input string name, input logic got, input logic exp);
    assert (got === exp)
    else
    begin
      $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_errors_start)
      $display("test %0d %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: FAIL, %0d errors", tests_run, name, errors - test_errors_start);
    end
    test_errors_start = errors;
  endtask

  task automatic send_tag_frame(input logic [noc_io_link_pkg::TAG_ID_W-1:0] id,
                                input logic en);
    logic [noc_io_link_pkg::TAG_FRAME_LEN-1:0] bits;
    int                                        i;
    bits = tag_frame_bits(id, en);
    for (i = noc_io_link_pkg::TAG_FRAME_LEN - 1; i >= 0; i--)
    begin
      @(negedge io_clk_i);
      tag_en_i   = 1'b1;
      tag_data_i = bits[i];
    end
    @(negedge io_clk_i);
    tag_en_i   = 1'b0;
    tag_data_i = 1'b0;
  endtask

  task automatic wait_ready(input logic level);
    int waited;
    waited = 0;
    while (core_ready_o !== level && waited < TIMEOUT_CYCLES)
    begin
      @(negedge io_clk_i);
      waited++;
    end
    if (core_ready_o !== level)
    begin
      $display("%0t: core_ready_o never went to %b before the timeout", $time, level);
      errors++;
    end
  endtask

  // one flit to the core port, called right after a falling edge
  task automatic drive_flit();
    noc_io_link_pkg::flit_t flit;
    flit        = noc_io_link_pkg::flit_t'($urandom);
    core_v_i    = 1'b1;
    core_data_i = flit;
    tx_expect.push_back(flit);
  endtask

  task automatic send_core_flits(input int n);
    int sent;
    int waited;
    sent   = 0;
    waited = 0;
    while (sent < n && waited < TIMEOUT_CYCLES)
    begin
      @(negedge io_clk_i);
      core_v_i = 1'b0;
      // random idle cycles between flits
      if (core_ready_o && ($urandom % 3 != 0))
      begin
        drive_flit();
        sent++;
        waited = 0;
      end
      else
        waited++;
    end
    @(negedge io_clk_i);
    core_v_i = 1'b0;
    if (sent < n)
    begin
      $display("%0t: core port stalled, %0d of %0d flits accepted", $time, sent, n);
      errors++;
    end
  endtask

  task automatic fill_until_blocked();
    int   waited;
    logic blocked;
    waited  = 0;
    blocked = 1'b0;
    while (!blocked && waited < TIMEOUT_CYCLES)
    begin
      @(negedge io_clk_i);
      waited++;
      if (core_ready_o)
        drive_flit();
      else
      begin
        core_v_i = 1'b0;
        blocked  = 1'b1;
      end
    end
    if (!blocked)
    begin
      @(negedge io_clk_i);
      core_v_i = 1'b0;
      $display("%0t: core_ready_o stayed high with tokens withheld", $time);
      errors++;
    end
  endtask

  // tx queue empty and every token back home
  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((tx_expect.size() != 0 || owed_tokens != 0) && waited < TIMEOUT_CYCLES)
    begin
      @(negedge io_clk_i);
      waited++;
    end
    if (tx_expect.size() != 0 || owed_tokens != 0)
    begin
      $display("%0t: %0d flits never left on the link", $time, tx_expect.size());
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // remote side

  // owes one token per flit, pays back after a random gap
  always @(negedge io_clk_i)
  begin
    link_token_i = 1'b0;
    if (link_v_o)
      owed_tokens++;
    if (token_gap > 0)
      token_gap--;
    else if (owed_tokens > 0 && !hold_tokens)
    begin
      link_token_i = 1'b1;
      owed_tokens--;
      token_gap = $urandom % 4;
    end
  end

  ////////////////////////////////////////
  // compare

  // just after the falling edge, outputs and strobes both settled
  always @(negedge io_clk_i)
  begin
    #1;
    if (link_v_o)
    begin
      link_v_count++;
      if (hold_tokens)
        held_sends++;
      assert (tx_expect.size() > 0)
      else
      begin
        $display("%0t: flit %h left on the link with none expected", $time, link_data_o);
        errors++;
      end
      if (tx_expect.size() > 0)
      begin
        assert (link_data_o === tx_expect[0])
        else
        begin
          $display("ERROR %0t link_data_o got %h expected %h", $time, link_data_o,
                   tx_expect[0]);
          errors++;
        end
        void'(tx_expect.pop_front());
      end
    end
    if (out_yumi_i)
    begin
      rx_deqs++;
      assert (rx_expect.size() > 0)
      else
      begin
        $display("%0t: core dequeued a flit that was never sent", $time);
        errors++;
      end
      if (rx_expect.size() > 0)
      begin
        assert (out_data_o === rx_expect[0])
        else
        begin
          $display("ERROR %0t out_data_o got %h expected %h", $time, out_data_o,
                   rx_expect[0]);
          errors++;
        end
        void'(rx_expect.pop_front());
      end
    end
    if (link_token_o)
      token_pulses++;
  end

  ////////////////////////////////////////
  // test sequence

  initial
  begin : main
    int n;
    int i;
    int waited;
    int sends_before;
    void'($urandom(SEED));
    rst_n_i     = 1'b0;
    tag_en_i    = 1'b0;
    tag_data_i  = 1'b0;
    core_v_i    = 1'b0;
    core_data_i = '0;
    link_v_i    = 1'b0;
    link_data_i = '0;
    out_yumi_i  = 1'b0;
    repeat (5) @(negedge io_clk_i);
    rst_n_i = 1'b1;

    // reset levels, then a frame for another node
    @(negedge io_clk_i);
    check_level("link_v_o", link_v_o, 1'b0);
    check_level("link_token_o", link_token_o, 1'b0);
    check_level("out_v_o", out_v_o, 1'b0);
    check_level("core_ready_o", core_ready_o, 1'b0);
    send_tag_frame(4'd3, 1'b1);
    repeat (10) @(negedge io_clk_i);
    check_level("core_ready_o", core_ready_o, 1'b0);
    finish_test("reset state and foreign frame");

    send_tag_frame(noc_io_link_pkg::TAG_NODE_ID, 1'b1);
    wait_ready(1'b1);
    finish_test("enable by own id");

    send_core_flits(RANDOM_FLITS);
    wait_drain();
    finish_test("random flits with token return");

    // credits run out, buffer fills behind them
    hold_tokens = 1'b1;
    held_sends  = 0;
    fill_until_blocked();
    assert (held_sends <= noc_io_link_pkg::LINK_CREDITS)
    else
    begin
      $display("ERROR %0t link_v_o pulses got %0d expected at most %0d", $time,
               held_sends, noc_io_link_pkg::LINK_CREDITS);
      errors++;
    end
    hold_tokens = 1'b0;
    wait_drain();
    finish_test("back-pressure without tokens");

    // rx side, burst in then random dequeues
    n = 1 + int'($urandom % noc_io_link_pkg::LINK_CREDITS);
    for (i = 0; i < n; i++)
    begin
      @(negedge io_clk_i);
      link_v_i    = 1'b1;
      link_data_i = noc_io_link_pkg::flit_t'($urandom);
      rx_expect.push_back(link_data_i);
    end
    @(negedge io_clk_i);
    link_v_i = 1'b0;
    waited   = 0;
    i        = 0;
    while (i < n && waited < TIMEOUT_CYCLES)
    begin
      @(negedge io_clk_i);
      out_yumi_i = 1'b0;
      waited++;
      if (out_v_o && ($urandom % 2 == 1))
      begin
        out_yumi_i = 1'b1;
        i++;
      end
    end
    @(negedge io_clk_i);
    out_yumi_i = 1'b0;
    if (i < n)
    begin
      $display("%0t: out_v_o dropped with %0d flits still expected", $time, n - i);
      errors++;
    end
    waited = 0;
    while (token_pulses != rx_deqs && waited < TIMEOUT_CYCLES)
    begin
      @(negedge io_clk_i);
      waited++;
    end
    repeat (2) @(negedge io_clk_i);
    assert (token_pulses == rx_deqs)
    else
    begin
      $display("ERROR %0t link_token_o pulses got %0d expected %0d", $time,
               token_pulses, rx_deqs);
      errors++;
    end
    finish_test("rx dequeue and token return");

    // one flit stuck behind the spent credits when the link goes down
    hold_tokens = 1'b1;
    send_core_flits(noc_io_link_pkg::LINK_CREDITS + 1);
    send_tag_frame(noc_io_link_pkg::TAG_NODE_ID, 1'b0);
    wait_ready(1'b0);
    sends_before = link_v_count;
    repeat (20)
    begin
      @(negedge io_clk_i);
      core_v_i    = 1'b1;
      core_data_i = noc_io_link_pkg::flit_t'($urandom);
    end
    @(negedge io_clk_i);
    core_v_i = 1'b0;
    repeat (3) @(negedge io_clk_i);
    assert (link_v_count == sends_before)
    else
    begin
      $display("ERROR %0t link_v_o pulses got %0d expected %0d", $time,
               link_v_count - sends_before, 0);
      errors++;
    end
    finish_test("disable by own id");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== noc_io_link.f ====
rtl/noc_io_link_pkg.sv
rtl/tag_client_fsm.sv
rtl/credit_counter.sv
rtl/flit_fifo.sv
rtl/link_tx.sv
rtl/link_rx.sv
rtl/noc_io_link.sv
test/noc_io_link_tb.sv

// ==== Makefile ====
TOP = noc_io_link_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
	  --top-module $(TOP) -f noc_io_link.f -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
